/* hdl/tetris_pkg.sv */
//////////////////////////////
// Shared types and cell colours for the VRAM path
//////////////////////////////
package tetris_pkg;

	typedef logic [15:0] word_t;   // Board row or SDRAM word, bit n = column n
	typedef logic [24:0] addr_t;   // SDRAM word address
	typedef logic [9:0]  coord_t;  // Pixel coordinate
	typedef logic [7:0]  color_t;  // One colour channel

	// Occupied cell
	localparam color_t FILL_RED   = 8'hf0;
	localparam color_t FILL_GREEN = 8'h90;
	localparam color_t FILL_BLUE  = 8'h10;

	// Empty cell inside the strip, dark grey
	localparam color_t BACK_RED   = 8'h20;
	localparam color_t BACK_GREEN = 8'h20;
	localparam color_t BACK_BLUE  = 8'h30;

	// Cells are 8x8 pixels
	localparam int CELL_SHIFT = 3;

endpackage

/* hdl/vga_timing.sv */
//////////////////////////////
// Counters free-run from reset, sync levels are active high
// Frame sizes must fit in 10 bits
//////////////////////////////
`timescale 1ns/1ps

module vga_timing #(
	parameter int H_TOTAL  = 160,
	parameter int V_TOTAL  = 40,
	parameter int VS_LINES = 2
) (
	input  logic               clk,
	input  logic               reset,
	output tetris_pkg::coord_t draw_x,
	output tetris_pkg::coord_t draw_y,
	output logic               hs,
	output logic               vs
);

	tetris_pkg::coord_t next_x;
	tetris_pkg::coord_t next_y;
	logic               line_end;

	assign line_end = (draw_x == tetris_pkg::coord_t'(H_TOTAL - 1));

	// Next position, x wraps first and carries into y
	always_comb begin
		next_x = draw_x + 1'b1;
		next_y = draw_y;
		if (line_end) begin
			next_x = '0;
			if (draw_y == tetris_pkg::coord_t'(V_TOTAL - 1))
				next_y = '0; // Frame wrap
			else
				next_y = draw_y + 1'b1;
		end
	end

	// Sync decoded from the next count so it lines up with draw_x/draw_y
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			draw_x <= '0;
			draw_y <= '0;
			hs     <= 1'b1; // Pixel (0,0) sits inside both pulses
			vs     <= 1'b1;
		end else begin
			draw_x <= next_x;
			draw_y <= next_y;
			hs     <= (next_x < tetris_pkg::coord_t'(16));
			vs     <= (next_y < tetris_pkg::coord_t'(VS_LINES));
		end
	end

endmodule

/* hdl/board_shadow.sv */
//////////////////////////////
// ROWS must be at least 2
// Edit wins over a same-cycle flush_done
//////////////////////////////
`timescale 1ns/1ps

module board_shadow #(
	parameter int ROWS = 4
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    edit_we,
	input  logic [$clog2(ROWS)-1:0] edit_row,
	input  tetris_pkg::word_t       edit_bits,
	input  logic [$clog2(ROWS)-1:0] row_sel,
	output tetris_pkg::word_t       row_bits,
	output logic                    dirty,
	input  logic                    flush_done
);

	tetris_pkg::word_t rows [ROWS]; // Staging copy of the board

	// Board starts empty
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < ROWS; i++)
				rows[i] <= '0;
		end else if (edit_we && edit_row < ROWS) begin
			rows[edit_row] <= edit_bits;
		end
	end

	// Changed since last flush
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			dirty <= 1'b0;
		else if (edit_we)
			dirty <= 1'b1; // New edit keeps it set
		else if (flush_done)
			dirty <= 1'b0;
	end

	// Sequencer picks the row, read is combinational
	assign row_bits = (row_sel < ROWS) ? rows[row_sel] : '0;

endmodule

/* hdl/vram_sequencer.sv */
//////////////////////////////
// Strobes decode from state, req drops with wr_full/rd_empty
// Flush has priority, a read seen meanwhile waits for idle
//////////////////////////////
`timescale 1ns/1ps

module vram_sequencer #(
	parameter int                ROWS      = 4,
	parameter tetris_pkg::addr_t VRAM_BASE = '0
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    vs,
	input  tetris_pkg::coord_t      draw_x,
	input  tetris_pkg::coord_t      draw_y,
	input  logic                    dirty,
	input  tetris_pkg::word_t       row_bits,
	input  logic                    wr_full,
	input  logic                    rd_empty,
	input  tetris_pkg::word_t       readdata,
	output logic [$clog2(ROWS)-1:0] row_sel,
	output logic                    flush_done,
	output logic                    write_ld,
	output logic                    write_req,
	output tetris_pkg::addr_t       writeaddr,
	output tetris_pkg::word_t       writedata,
	output logic                    read_ld,
	output logic                    read_req,
	output tetris_pkg::addr_t       readaddr,
	output tetris_pkg::word_t       row_a,
	output tetris_pkg::word_t       row_b,
	output logic [3:0]              hex_num_4,
	output logic [3:0]              hex_num_3,
	output logic [3:0]              hex_num_1,
	output logic [3:0]              hex_num_0
);

	typedef enum logic [3:0] {
		IDLE,
		W_LOAD, W_REQ, W_GAP, W_DONE,     // Per-row write loop
		R_LD_A, R_RQ_A, R_CAP_A,          // First word
		R_LD_B, R_RQ_B, R_CAP_B           // Second word
	} state_t;

	state_t                  state;
	logic [$clog2(ROWS)-1:0] row;        // Row being flushed
	logic                    vs_q;
	logic                    vs_rise;
	logic                    flush_pend; // Dirty board seen at vs rise
	logic                    read_pend;  // Pixel (0,0) seen

	assign vs_rise = vs & ~vs_q;

	// Edge detect and pending requests, later assignment wins
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			vs_q       <= 1'b1; // vs leaves reset high
			flush_pend <= 1'b0;
			read_pend  <= 1'b0;
		end else begin
			vs_q <= vs;
			if (state == IDLE && flush_pend)
				flush_pend <= 1'b0;
			if (vs_rise && dirty)
				flush_pend <= 1'b1;
			if (state == IDLE && !flush_pend && read_pend)
				read_pend <= 1'b0;
			if (draw_x == '0 && draw_y == '0)
				read_pend <= 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			row   <= '0;
			row_a <= '0;
			row_b <= '0;
		end else begin
			unique case (state)
				IDLE: begin
					if (flush_pend) begin
						row   <= '0;
						state <= W_LOAD;
					end else if (read_pend) begin
						state <= R_LD_A;
					end
				end
				W_LOAD: state <= W_REQ;
				W_REQ:  if (!wr_full) state <= W_GAP; // Held off while FIFO full
				W_GAP: begin
					if (row == ROWS - 1) begin
						state <= W_DONE;
					end else begin
						row   <= row + 1'b1;
						state <= W_LOAD;
					end
				end
				W_DONE:  state <= IDLE;
				R_LD_A:  state <= R_RQ_A;
				R_RQ_A:  if (!rd_empty) state <= R_CAP_A;
				R_CAP_A: begin
					row_a <= readdata; // Valid the cycle after read_req
					state <= R_LD_B;
				end
				R_LD_B:  state <= R_RQ_B;
				R_RQ_B:  if (!rd_empty) state <= R_CAP_B;
				R_CAP_B: begin
					row_b <= readdata;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Write port
	assign row_sel    = row;
	assign write_ld   = (state == W_LOAD);
	assign write_req  = (state == W_REQ) && !wr_full;
	assign writeaddr  = VRAM_BASE + tetris_pkg::addr_t'(row);
	assign writedata  = row_bits; // Shadow word for the current row
	assign flush_done = (state == W_DONE);

	// Read port, B reads the next word up
	assign read_ld  = (state == R_LD_A) || (state == R_LD_B);
	assign read_req = ((state == R_RQ_A) || (state == R_RQ_B)) && !rd_empty;
	assign readaddr = (state == R_LD_B) ? VRAM_BASE + tetris_pkg::addr_t'(1) : VRAM_BASE;

	// Low byte of each word on the hex digits
	assign hex_num_0 = row_a[3:0];
	assign hex_num_1 = row_a[7:4];
	assign hex_num_3 = row_b[3:0];
	assign hex_num_4 = row_b[7:4];

endmodule

/* hdl/color_mapper.sv */
//////////////////////////////
// Strip is 16x2 cells at top left
//////////////////////////////
`timescale 1ns/1ps

module color_mapper (
	input  tetris_pkg::coord_t draw_x,
	input  tetris_pkg::coord_t draw_y,
	input  tetris_pkg::word_t  row_a,
	input  tetris_pkg::word_t  row_b,
	output tetris_pkg::color_t red,
	output tetris_pkg::color_t green,
	output tetris_pkg::color_t blue
);

	tetris_pkg::coord_t cell_x;
	tetris_pkg::coord_t cell_y;
	tetris_pkg::word_t  line_word; // Row shown on this line
	logic               in_strip;
	logic               occupied;

	assign cell_x = draw_x >> tetris_pkg::CELL_SHIFT;
	assign cell_y = draw_y >> tetris_pkg::CELL_SHIFT;

	// Columns 0-15, cell rows 0-1
	assign in_strip  = (cell_x < tetris_pkg::coord_t'(16)) && (cell_y < tetris_pkg::coord_t'(2));
	assign line_word = cell_y[0] ? row_b : row_a;
	assign occupied  = line_word[cell_x[3:0]];

	always_comb begin
		if (!in_strip) begin
			red   = '0; // Black outside
			green = '0;
			blue  = '0;
		end else if (occupied) begin
			red   = tetris_pkg::FILL_RED;
			green = tetris_pkg::FILL_GREEN;
			blue  = tetris_pkg::FILL_BLUE;
		end else begin
			red   = tetris_pkg::BACK_RED;
			green = tetris_pkg::BACK_GREEN;
			blue  = tetris_pkg::BACK_BLUE;
		end
	end

endmodule

/* hdl/tetris_vram.sv */
//////////////////////////////
// SDRAM controller FIFO ports are external
//////////////////////////////
`timescale 1ns/1ps

module tetris_vram #(
	parameter int                ROWS      = 4,
	parameter tetris_pkg::addr_t VRAM_BASE = '0,
	parameter int                H_TOTAL   = 160,
	parameter int                V_TOTAL   = 40,
	parameter int                VS_LINES  = 2
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    edit_we,
	input  logic [$clog2(ROWS)-1:0] edit_row,
	input  tetris_pkg::word_t       edit_bits,
	input  logic                    wr_full,
	input  logic                    rd_empty,
	input  tetris_pkg::word_t       readdata,
	output logic                    hs,
	output logic                    vs,
	output logic                    write_ld,
	output logic                    write_req,
	output tetris_pkg::addr_t       writeaddr,
	output tetris_pkg::word_t       writedata,
	output logic                    read_ld,
	output logic                    read_req,
	output tetris_pkg::addr_t       readaddr,
	output tetris_pkg::color_t      red,
	output tetris_pkg::color_t      green,
	output tetris_pkg::color_t      blue,
	output logic [3:0]              hex_num_4,
	output logic [3:0]              hex_num_3,
	output logic [3:0]              hex_num_1,
	output logic [3:0]              hex_num_0
);

	tetris_pkg::coord_t      draw_x;
	tetris_pkg::coord_t      draw_y;
	logic [$clog2(ROWS)-1:0] row_sel;
	tetris_pkg::word_t       row_bits;
	logic                    dirty;
	logic                    flush_done;
	tetris_pkg::word_t       row_a; // Read-back words for display
	tetris_pkg::word_t       row_b;

	vga_timing #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL), .VS_LINES(VS_LINES)) u_timing (
		.clk(clk), .reset(reset), .draw_x(draw_x), .draw_y(draw_y), .hs(hs), .vs(vs)
	);

	board_shadow #(.ROWS(ROWS)) u_board (
		.clk(clk), .reset(reset), .edit_we(edit_we), .edit_row(edit_row),
		.edit_bits(edit_bits), .row_sel(row_sel), .row_bits(row_bits),
		.dirty(dirty), .flush_done(flush_done)
	);

	vram_sequencer #(.ROWS(ROWS), .VRAM_BASE(VRAM_BASE)) u_seq (
		.clk(clk), .reset(reset), .vs(vs), .draw_x(draw_x), .draw_y(draw_y),
		.dirty(dirty), .row_bits(row_bits), .wr_full(wr_full), .rd_empty(rd_empty),
		.readdata(readdata), .row_sel(row_sel), .flush_done(flush_done),
		.write_ld(write_ld), .write_req(write_req), .writeaddr(writeaddr),
		.writedata(writedata), .read_ld(read_ld), .read_req(read_req),
		.readaddr(readaddr), .row_a(row_a), .row_b(row_b),
		.hex_num_4(hex_num_4), .hex_num_3(hex_num_3),
		.hex_num_1(hex_num_1), .hex_num_0(hex_num_0)
	);

	color_mapper u_color (
		.draw_x(draw_x), .draw_y(draw_y), .row_a(row_a), .row_b(row_b),
		.red(red), .green(green), .blue(blue)
	);

endmodule

/* tb/tb_clock.sv */
//////////////////////////////
// Free-running, starts low
//////////////////////////////
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 20 // ns
) (
	output logic clk
);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

endmodule

/* tb/tetris_vram_assertions.sv */
//////////////////////////////
// Bound into vram_sequencer, strobes sampled on clk
//////////////////////////////
`timescale 1ns/1ps

module tetris_vram_assertions (
	input logic clk,
	input logic reset,
	input logic wr_full,
	input logic rd_empty,
	input logic write_ld,
	input logic write_req,
	input logic read_ld,
	input logic read_req
);

	// FIFO flags gate the requests
	no_write_when_full: assert property (@(posedge clk) disable iff (reset) !(write_req && wr_full))
		else $error("write_req raised while wr_full is high");
	no_read_when_empty: assert property (@(posedge clk) disable iff (reset) read_req |-> !rd_empty)
		else $error("read_req raised while rd_empty is high");

	// Single-cycle strobes
	write_ld_pulse: assert property (@(posedge clk) disable iff (reset) write_ld |=> !write_ld)
		else $error("write_ld held longer than one cycle");
	write_req_pulse: assert property (@(posedge clk) disable iff (reset) write_req |=> !write_req)
		else $error("write_req held longer than one cycle");
	read_ld_pulse: assert property (@(posedge clk) disable iff (reset) read_ld |=> !read_ld)
		else $error("read_ld held longer than one cycle");
	read_req_pulse: assert property (@(posedge clk) disable iff (reset) read_req |=> !read_req)
		else $error("read_req held longer than one cycle");

endmodule

bind vram_sequencer tetris_vram_assertions u_assertions (
	.clk(clk), .reset(reset), .wr_full(wr_full), .rd_empty(rd_empty),
	.write_ld(write_ld), .write_req(write_req), .read_ld(read_ld), .read_req(read_req)
);

/* tb/tetris_vram_tb.sv */
//////////////////////////////
// Models both SDRAM FIFO ports, one golden record per frame
// Run from the project root so the golden path resolves
//////////////////////////////
`timescale 1ns/1ps

module tetris_vram_tb;

	localparam int                ROWS      = 4;
	localparam tetris_pkg::addr_t VRAM_BASE = '0;
	localparam int                H_TOTAL   = 160;
	localparam int                V_TOTAL   = 40;
	localparam int                VS_LINES  = 2;
	localparam int                NUM_TESTS = 6;
	localparam int                FIELDS    = 15; // Values per golden record

	logic                    clk;
	logic                    reset;
	logic                    edit_we;
	logic [$clog2(ROWS)-1:0] edit_row;
	tetris_pkg::word_t       edit_bits;
	logic                    wr_full;
	logic                    rd_empty;
	tetris_pkg::word_t       readdata;
	logic                    hs;
	logic                    vs;
	logic                    write_ld;
	logic                    write_req;
	tetris_pkg::addr_t       writeaddr;
	tetris_pkg::word_t       writedata;
	logic                    read_ld;
	logic                    read_req;
	tetris_pkg::addr_t       readaddr;
	tetris_pkg::color_t      red;
	tetris_pkg::color_t      green;
	tetris_pkg::color_t      blue;
	logic [3:0]              hex_num_4;
	logic [3:0]              hex_num_3;
	logic [3:0]              hex_num_1;
	logic [3:0]              hex_num_0;

	tetris_pkg::word_t gold [NUM_TESTS*FIELDS];
	tetris_pkg::word_t rec [FIELDS];              // Record of the running frame
	tetris_pkg::word_t wmem [tetris_pkg::addr_t]; // VRAM behind the write FIFO
	tetris_pkg::word_t read_q [$];                // Words the read FIFO serves
	tetris_pkg::word_t delay_q [$];               // rd_empty delay per word
	tetris_pkg::word_t exp_a;                     // Expected row_a
	tetris_pkg::word_t exp_b;
	tetris_pkg::word_t serve_word;
	tetris_pkg::addr_t wr_addr;                   // Latched on write_ld
	integer            seed = 39206;
	int                errors;
	int                checks;
	int                test_idx;
	int                px;                        // Pixel count since reset
	int                py;
	int                wr_count;
	int                rd_count;
	int                rd_wait;
	int                serve_target;              // 1 word A, 2 word B
	int                cap_target;
	logic              rd_active;

	tb_clock #(.PERIOD(20)) u_clock (.clk(clk));

	tetris_vram #(
		.ROWS(ROWS), .VRAM_BASE(VRAM_BASE), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL),
		.VS_LINES(VS_LINES)
	) dut (
		.clk(clk), .reset(reset), .edit_we(edit_we), .edit_row(edit_row),
		.edit_bits(edit_bits), .wr_full(wr_full), .rd_empty(rd_empty), .readdata(readdata),
		.hs(hs), .vs(vs), .write_ld(write_ld), .write_req(write_req), .writeaddr(writeaddr),
		.writedata(writedata), .read_ld(read_ld), .read_req(read_req), .readaddr(readaddr),
		.red(red), .green(green), .blue(blue), .hex_num_4(hex_num_4),
		.hex_num_3(hex_num_3), .hex_num_1(hex_num_1), .hex_num_0(hex_num_0)
	);

	task automatic check_word(input string name, input tetris_pkg::word_t got,
		input tetris_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input tetris_pkg::addr_t got,
		input tetris_pkg::addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_color(input string name, input tetris_pkg::color_t got,
		input tetris_pkg::color_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	// Falling-edge drive of edits and both FIFO flags
	task automatic drive_inputs();
		reset = 1'b0;
		if (py == 20 && px < ROWS) begin // Edits on line 20, one row per clock
			edit_we   = rec[10][px];
			edit_row  = px[$clog2(ROWS)-1:0];
			edit_bits = rec[11+px];
		end else begin
			edit_we = 1'b0;
		end
		wr_full = (rec[1] != 0) && ($random(seed) % 2 != 0); // Random stalls
		// Captured word reaches row_a/row_b a clock after it is served
		if (cap_target == 1)
			exp_a = serve_word;
		if (cap_target == 2)
			exp_b = serve_word;
		cap_target   = serve_target;
		serve_target = 0;
		readdata     = (cap_target != 0) ? serve_word : tetris_pkg::word_t'($random(seed));
		if (rd_active && rd_wait == 0) begin
			rd_empty = 1'b0;
		end else begin
			rd_empty = 1'b1; // Idle FIFO reads as empty
			if (rd_active)
				rd_wait--;
		end
	endtask

	task automatic observe_outputs();
		logic              in_strip;
		logic              occ;
		tetris_pkg::word_t d;
		if (test_idx == 0 && py == 0 && px < 2) begin // Quiet right after reset
			if (write_ld || write_req || read_ld || read_req)
				note_failure("strobe high before the first frame event");
			check_word("hex digits", {hex_num_4, hex_num_3, hex_num_1, hex_num_0}, '0);
		end
		if (write_ld) begin
			if (rec[0] == 0)
				note_failure("write_ld in a frame without pending edits");
			else if (wr_count == 0 && !(px == 2 && py == 0))
				note_failure("first write_ld not 2 clocks after the vs rise");
			check_addr("writeaddr", writeaddr, VRAM_BASE + tetris_pkg::addr_t'(wr_count));
			wr_addr = writeaddr;
		end
		if (write_req) begin
			if (wr_full)
				note_failure("write_req while wr_full is high");
			if (rec[0] == 0 || wr_count >= ROWS)
				note_failure("write_req beyond the expected writes");
			else
				check_word("writedata", writedata, rec[2+wr_count]);
			wmem[wr_addr] = writedata;
			wr_count++;
		end
		if (read_ld) begin
			check_addr("readaddr", readaddr, VRAM_BASE + tetris_pkg::addr_t'(rd_count));
			d = (delay_q.size() != 0) ? delay_q.pop_front() : '0;
			rd_wait = (d == 16'h00ff) ? $unsigned($random(seed)) % 8 : int'(d); // ff = random
			rd_active = 1'b1;
			rd_count++;
		end
		if (read_req) begin
			if (rd_empty)
				note_failure("read_req while rd_empty is high");
			if (read_q.size() == 0) begin
				note_failure("read_req with no word left in the read FIFO");
			end else begin
				serve_word   = read_q.pop_front();
				serve_target = rd_count;
			end
			rd_active = 1'b0;
		end
		// 16x2 strip of 8x8 cells, black elsewhere
		in_strip = (px < 128) && (py < 16);
		occ      = 1'b0;
		if (in_strip)
			occ = (py < 8) ? exp_a[px >> 3] : exp_b[px >> 3];
		check_color("red", red,
			!in_strip ? 8'h00 : occ ? tetris_pkg::FILL_RED : tetris_pkg::BACK_RED);
		check_color("green", green,
			!in_strip ? 8'h00 : occ ? tetris_pkg::FILL_GREEN : tetris_pkg::BACK_GREEN);
		check_color("blue", blue,
			!in_strip ? 8'h00 : occ ? tetris_pkg::FILL_BLUE : tetris_pkg::BACK_BLUE);
		check_bit("hs", hs, px < 16);       // First 16 clocks of each line
		check_bit("vs", vs, py < VS_LINES);
	endtask

	task automatic step();
		@(negedge clk);
		drive_inputs();
		#1; // Outputs settled well before the next rising edge
		observe_outputs();
		if (px == H_TOTAL - 1) begin
			px = 0;
			py = (py == V_TOTAL - 1) ? 0 : py + 1;
		end else begin
			px++;
		end
	endtask

	task automatic check_frame_end();
		if (rec[0] != 0) begin
			if (wr_count != ROWS)
				note_failure($sformatf("%0d writes in the flush, expected %0d", wr_count, ROWS));
			for (int r = 0; r < ROWS; r++)
				check_word($sformatf("vram[%0d]", r), wmem[VRAM_BASE + tetris_pkg::addr_t'(r)],
					rec[2+r]);
		end else if (wr_count != 0) begin
			note_failure("write_req in a frame with no edits since the last flush");
		end
		if (rd_count != 2 || read_q.size() != 0)
			note_failure("readback did not finish both words");
		check_word("hex digits", {hex_num_4, hex_num_3, hex_num_1, hex_num_0},
			{rec[7][7:0], rec[6][7:0]});
	endtask

	initial begin
		int errs_before;
		reset        = 1'b1;
		edit_we      = 1'b0;
		edit_row     = '0;
		edit_bits    = '0;
		wr_full      = 1'b0;
		rd_empty     = 1'b1;
		readdata     = '0;
		errors       = 0;
		checks       = 0;
		px           = 0;
		py           = 0;
		exp_a        = '0;
		exp_b        = '0;
		serve_word   = '0;
		serve_target = 0;
		cap_target   = 0;
		rd_active    = 1'b0;
		rd_wait      = 0;
		wr_addr      = '0;
		test_idx     = 0;
		$readmemh("tb/tetris_vram_golden.txt", gold);
		if ($isunknown(gold[NUM_TESTS*FIELDS-1]))
			note_failure("golden file missing or short");
		repeat (9) @(negedge clk); // First step drops reset after 10 rising edges
		for (test_idx = 0; test_idx < NUM_TESTS; test_idx++) begin
			errs_before = errors;
			for (int f = 0; f < FIELDS; f++)
				rec[f] = gold[test_idx*FIELDS + f];
			read_q.delete();
			delay_q.delete();
			read_q.push_back(rec[6]);
			read_q.push_back(rec[7]);
			delay_q.push_back(rec[8]);
			delay_q.push_back(rec[9]);
			wr_count = 0;
			rd_count = 0;
			repeat (H_TOTAL * V_TOTAL) step();
			check_frame_end();
			$display("test %0d: %0d writes, %0d reads, %s", test_idx, wr_count, rd_count,
				(errors == errs_before) ? "ok" : "errors");
		end
		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Two spare frames beyond the tests
	initial begin
		repeat ((NUM_TESTS + 2) * H_TOTAL * V_TOTAL) @(posedge clk);
		$display("Error at %0t ns: watchdog expired before the tests finished", $time);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* tb/tetris_vram_golden.txt */
// One frame per line: wr_exp full x0 x1 x2 x3 ra rb da db mask e0 e1 e2 e3
// x = flush words at frame start, ra/rb read FIFO words, da/db rd_empty delay (ff = random)
// mask/e = rows edited on line 20, flushed at the next frame
0000 0000 0000 0000 0000 0000 00a5 003c 0000 0002 000f 8001 4002 2004 1008
0001 0000 8001 4002 2004 1008 8001 4002 00ff 0001 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 8001 4002 0003 00ff 0005 ffff 0000 0f0f 0000
0001 0001 ffff 4002 0f0f 1008 ffff 4002 00ff 00ff 0002 0000 c3c3 0000 0000
0001 0001 ffff c3c3 0f0f 1008 ffff c3c3 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 5a96 1e78 0005 00ff 0000 0000 0000 0000 0000

/* tetris_vram.f */
hdl/tetris_pkg.sv
hdl/vga_timing.sv
hdl/board_shadow.sv
hdl/vram_sequencer.sv
hdl/color_mapper.sv
hdl/tetris_vram.sv
tb/tb_clock.sv
tb/tetris_vram_assertions.sv
tb/tetris_vram_tb.sv

/* Bender.yml */
package:
  name: tetris_vram

sources:
  - files:
      - hdl/tetris_pkg.sv
      - hdl/vga_timing.sv
      - hdl/board_shadow.sv
      - hdl/vram_sequencer.sv
      - hdl/color_mapper.sv
      - hdl/tetris_vram.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/tetris_vram_assertions.sv
      - tb/tetris_vram_tb.sv
